// File: verilog.f
logic/sb_pkg.sv
logic/inst_decoder.sv
logic/fu_status_table.sv
logic/operand_read_arbiter.sv
logic/writeback_arbiter.sv
logic/scoreboard_ctrl.sv
verif/tb_clock.sv
verif/scoreboard_ctrl_tb.sv

// File: verif/scoreboard_ctrl_tb.sv
`timescale 1ns/1ps

module scoreboard_ctrl_tb;
    import sb_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int TEST_SLOTS  = 10;
    localparam int TEST_CYCLES = 40;
    localparam int WAIT_MAX    = 20;   // cycles per handshake wait

    logic        clk;
    logic        rst;
    logic        inst_valid;
    logic        inst_ready;
    logic [31:0] inst;
    logic [31:0] imm;
    imm_sel_e    imm_sel;
    logic        alu_done;
    logic        mem_done;
    logic        mul_done;
    logic        alu_en;
    logic        mem_en;
    logic        mul_en;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    logic [31:0] imm_out;
    logic [3:0]  alu_op;
    logic        alu_use_imm;
    logic        mem_we;
    logic [2:0]  mem_size;
    logic [1:0]  mul_op;
    logic        reg_write;
    wb_sel_e     write_sel;
    int          errors;
    logic [31:0] lfsr = 32'h66297d8c;

    tb_clock #(.PERIOD(CLK_PERIOD)) i_tb_clock (.clk(clk));

    scoreboard_ctrl #(.DATA_W(32)) i_scoreboard_ctrl (.*);

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_imm12();
        logic [11:0] v;
        for (int b = 0; b < 12; b++)
            v[b] = lfsr_step();
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] b,
                                           input logic [4:0] a, input logic [2:0] f3,
                                           input logic [4:0] d);
        return {f7, b, a, f3, d, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] i12, input logic [4:0] a,
                                           input logic [2:0] f3, input logic [4:0] d,
                                           input logic [6:0] opc);
        return {i12, a, f3, d, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] i12, input logic [4:0] b,
                                           input logic [4:0] a, input logic [2:0] f3);
        return {i12[11:5], b, a, f3, i12[4:0], 7'b0100011};
    endfunction

    function automatic logic event_on(input int idx);
        case (idx)
            0: return alu_en;
            1: return mem_en;
            2: return mul_en;
            default: return reg_write;
        endcase
    endfunction

    function automatic string event_name(input int idx);
        case (idx)
            0: return "alu_en";
            1: return "mem_en";
            2: return "mul_en";
            default: return "reg_write";
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("Mismatch in %s: expected %0h, actual %0h", name, exp, act);
    endtask

    task automatic present(input logic [31:0] i, input logic [31:0] im);
        @(posedge clk);
        #5;
        inst_valid = 1'b1;
        inst = i;
        imm = im;
    endtask

    // valid drops right after the accepting edge
    task automatic await_accept(input string name, input imm_sel_e exp_sel);
        int n;
        n = 0;
        @(negedge clk);
        while (!inst_ready && n < WAIT_MAX)
        begin
            @(negedge clk);
            n++;
        end
        if (!inst_ready)
        begin
            errors++;
            $display("%s: instruction was never accepted", name);
        end
        if (imm_sel !== exp_sel)
            report_mismatch({name, " imm_sel"}, exp_sel, imm_sel);
        @(posedge clk);
        #5;
        inst_valid = 1'b0;
    endtask

    task automatic issue(input string name, input logic [31:0] i, input logic [31:0] im,
                         input imm_sel_e exp_sel);
        present(i, im);
        await_accept(name, exp_sel);
    endtask

    // forbid < 0 means nothing is forbidden
    task automatic expect_event(input string name, input int idx, input int forbid);
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_MAX)
        begin
            @(negedge clk);
            n++;
            if (forbid >= 0 && event_on(forbid))
            begin
                errors++;
                $display("%s: %s came before %s", name, event_name(forbid), event_name(idx));
            end
            seen = event_on(idx);
        end
        if (!seen)
        begin
            errors++;
            $display("%s: timed out waiting for %s", name, event_name(idx));
        end
    endtask

    task automatic pulse_done(input int unit);
        @(posedge clk);
        #5;
        {mul_done, mem_done, alu_done} = 3'b001 << unit;
        @(posedge clk);
        #5;
        {mul_done, mem_done, alu_done} = 3'b000;
    endtask

    task automatic finish_unit(input string name, input int unit, input logic [4:0] exp_rd,
                               input wb_sel_e exp_sel);
        pulse_done(unit);
        expect_event(name, 3, -1);
        if (rd !== exp_rd)
            report_mismatch({name, " rd"}, exp_rd, rd);
        if (write_sel !== exp_sel)
            report_mismatch({name, " write_sel"}, exp_sel, write_sel);
    endtask

    task automatic test_add_path();
        issue("add_path", r_type(7'h00, 5'd2, 5'd1, 3'h0, 5'd3), 32'h0, imm_none);
        expect_event("add_path", 0, -1);
        if (rs1 !== 5'd1)
            report_mismatch("add_path rs1", 1, rs1);
        if (rs2 !== 5'd2)
            report_mismatch("add_path rs2", 2, rs2);
        if (alu_op !== 4'h0)
            report_mismatch("add_path alu_op", 0, alu_op);
        if (alu_use_imm !== 1'b0)
            report_mismatch("add_path alu_use_imm", 0, alu_use_imm);
        @(negedge clk);
        if (alu_en !== 1'b0)   // single read cycle
            report_mismatch("add_path alu_en", 0, alu_en);
        finish_unit("add_path", 0, 5'd3, wb_alu);
    endtask

    task automatic test_load_path();
        logic [31:0] im;
        im = rand_imm12();
        issue("load_path", i_type(im[11:0], 5'd6, 3'h2, 5'd5, 7'b0000011), im, imm_i);
        expect_event("load_path", 1, -1);
        if (mem_we !== 1'b0)
            report_mismatch("load_path mem_we", 0, mem_we);
        if (mem_size !== 3'b010)
            report_mismatch("load_path mem_size", 3'b010, mem_size);
        if (imm_out !== im)
            report_mismatch("load_path imm_out", im, imm_out);
        finish_unit("load_path", 1, 5'd5, wb_mem);
    endtask

    task automatic test_store_path();
        logic [31:0] im;
        im = rand_imm12();
        issue("store_path", s_type(im[11:0], 5'd8, 5'd7, 3'h2), im, imm_s);
        expect_event("store_path", 1, -1);
        if (mem_we !== 1'b1)
            report_mismatch("store_path mem_we", 1, mem_we);
        if (mem_size !== 3'b010)
            report_mismatch("store_path mem_size", 3'b010, mem_size);
        if (imm_out !== im)
            report_mismatch("store_path imm_out", im, imm_out);
        pulse_done(1);
        @(negedge clk);
        if (reg_write !== 1'b0)   // store frees its slot silently
            report_mismatch("store_path reg_write", 0, reg_write);
        issue("store_path", i_type(12'h010, 5'd7, 3'h2, 5'd13, 7'b0000011), 32'h10, imm_i);
        expect_event("store_path", 1, -1);
        finish_unit("store_path", 1, 5'd13, wb_mem);
    endtask

    task automatic test_issue_stalls();
        issue("structural", r_type(7'h00, 5'd2, 5'd1, 3'h0, 5'd10), 32'h0, imm_none);
        expect_event("structural", 0, -1);
        present(r_type(7'h00, 5'd2, 5'd1, 3'h0, 5'd11), 32'h0);
        @(negedge clk);
        if (inst_ready !== 1'b0)
            report_mismatch("structural inst_ready", 0, inst_ready);
        pulse_done(0);
        expect_event("structural", 3, -1);
        if (rd !== 5'd10)
            report_mismatch("structural rd", 10, rd);
        if (inst_ready !== 1'b0)
            report_mismatch("structural inst_ready at retire", 0, inst_ready);
        await_accept("structural", imm_none);
        expect_event("structural", 0, -1);
        finish_unit("structural", 0, 5'd11, wb_alu);

        // same rd on another unit
        issue("waw", r_type(7'h00, 5'd2, 5'd1, 3'h0, 5'd12), 32'h0, imm_none);
        expect_event("waw", 0, -1);
        present(r_type(7'h01, 5'd2, 5'd1, 3'h0, 5'd12), 32'h0);
        @(negedge clk);
        if (inst_ready !== 1'b0)
            report_mismatch("waw inst_ready", 0, inst_ready);
        pulse_done(0);
        expect_event("waw", 3, -1);
        if (inst_ready !== 1'b0)
            report_mismatch("waw inst_ready at retire", 0, inst_ready);
        await_accept("waw", imm_none);
        expect_event("waw", 2, -1);
        finish_unit("waw", 2, 5'd12, wb_mul);
    endtask

    task automatic test_raw_priority();
        issue("raw", r_type(7'h00, 5'd2, 5'd1, 3'h0, 5'd3), 32'h0, imm_none);
        expect_event("raw", 0, -1);
        issue("raw", r_type(7'h01, 5'd4, 5'd3, 3'h0, 5'd7), 32'h0, imm_none);
        pulse_done(0);
        expect_event("raw", 3, 2);
        if (rd !== 5'd3)
            report_mismatch("raw rd", 3, rd);
        expect_event("raw", 2, -1);
        if (rs1 !== 5'd3)
            report_mismatch("raw rs1", 3, rs1);
        if (mul_op !== 2'd0)
            report_mismatch("raw mul_op", 0, mul_op);
        finish_unit("raw", 2, 5'd7, wb_mul);

        // alu and mem both wake on x20
        issue("priority", r_type(7'h01, 5'd2, 5'd1, 3'h0, 5'd20), 32'h0, imm_none);
        expect_event("priority", 2, -1);
        issue("priority", r_type(7'h00, 5'd1, 5'd20, 3'h0, 5'd21), 32'h0, imm_none);
        issue("priority", i_type(12'h0, 5'd20, 3'h2, 5'd22, 7'b0000011), 32'h0, imm_i);
        pulse_done(2);
        expect_event("priority", 3, 0);
        expect_event("priority", 0, 1);
        expect_event("priority", 1, -1);
        finish_unit("priority", 0, 5'd21, wb_alu);
        finish_unit("priority", 1, 5'd22, wb_mem);
    endtask

    task automatic test_war_hold();
        issue("war", i_type(12'h0, 5'd6, 3'h2, 5'd4, 7'b0000011), 32'h0, imm_i);
        expect_event("war", 1, -1);
        issue("war", r_type(7'h01, 5'd9, 5'd4, 3'h0, 5'd8), 32'h0, imm_none);
        issue("war", r_type(7'h00, 5'd2, 5'd1, 3'h0, 5'd9), 32'h0, imm_none);
        expect_event("war", 0, -1);
        pulse_done(0);
        @(negedge clk);
        if (reg_write !== 1'b0)   // x9 still unread by the mul
            report_mismatch("war reg_write", 0, reg_write);
        pulse_done(1);
        expect_event("war", 3, -1);
        if (rd !== 5'd4)
            report_mismatch("war load rd", 4, rd);
        expect_event("war", 2, 3);
        if (rs2 !== 5'd9)
            report_mismatch("war rs2", 9, rs2);
        expect_event("war", 3, -1);
        if (rd !== 5'd9)
            report_mismatch("war add rd", 9, rd);
        finish_unit("war", 2, 5'd8, wb_mul);
    endtask

    initial
    begin
        #(TEST_SLOTS * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog: run took longer than %0d cycles", TEST_SLOTS * TEST_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        errors = 0;
        rst = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        imm = '0;
        {mul_done, mem_done, alu_done} = 3'b000;
        repeat (2) @(posedge clk);
        #5;
        rst = 1'b0;
        @(negedge clk);
        if ({alu_en, mem_en, mul_en, reg_write} !== 4'b0000)
            report_mismatch("reset outputs", 0, {alu_en, mem_en, mul_en, reg_write});

        test_add_path();
        test_load_path();
        test_store_path();
        test_issue_stalls();
        test_raw_priority();
        test_war_hold();

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

// File: logic/scoreboard_ctrl.sv
`timescale 1ns/1ps

module scoreboard_ctrl #(
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid,
    output logic              inst_ready,
    input  logic [31:0]       inst,
    input  logic [DATA_W-1:0] imm,
    output sb_pkg::imm_sel_e  imm_sel,
    input  logic              alu_done,
    input  logic              mem_done,
    input  logic              mul_done,
    output logic              alu_en,
    output logic              mem_en,
    output logic              mul_en,
    output sb_pkg::reg_addr_t rs1,
    output sb_pkg::reg_addr_t rs2,
    output logic [DATA_W-1:0] imm_out,
    output logic [3:0]        alu_op,
    output logic              alu_use_imm,
    output logic              mem_we,
    output logic [2:0]        mem_size,
    output logic [1:0]        mul_op,
    output logic              reg_write,
    output sb_pkg::wb_sel_e   write_sel,
    output sb_pkg::reg_addr_t rd
);
    import sb_pkg::*;

    // decoded instruction
    fu_e               fu;
    op_t               op;
    reg_addr_t         dst;
    reg_addr_t         src1;
    reg_addr_t         src2;

    fu_e               grant;
    fu_e               retire;

    // per-unit entry fields
    logic              entry_busy [1:NUM_FU];
    logic              entry_done [1:NUM_FU];
    logic              entry_rdy1 [1:NUM_FU];
    logic              entry_rdy2 [1:NUM_FU];
    op_t               entry_op   [1:NUM_FU];
    reg_addr_t         entry_dst  [1:NUM_FU];
    reg_addr_t         entry_src1 [1:NUM_FU];
    reg_addr_t         entry_src2 [1:NUM_FU];
    logic [DATA_W-1:0] entry_imm  [1:NUM_FU];

    inst_decoder i_inst_decoder (.*);

    fu_status_table #(.DATA_W(DATA_W)) i_fu_status_table (.*);

    operand_read_arbiter #(.DATA_W(DATA_W)) i_operand_read_arbiter (.*);

    writeback_arbiter i_writeback_arbiter (.*);

endmodule

// File: logic/writeback_arbiter.sv
`timescale 1ns/1ps

module writeback_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  logic              entry_busy [1:sb_pkg::NUM_FU],
    input  logic              entry_done [1:sb_pkg::NUM_FU],
    input  sb_pkg::reg_addr_t entry_dst  [1:sb_pkg::NUM_FU],
    input  sb_pkg::reg_addr_t entry_src1 [1:sb_pkg::NUM_FU],
    input  sb_pkg::reg_addr_t entry_src2 [1:sb_pkg::NUM_FU],
    input  logic              entry_rdy1 [1:sb_pkg::NUM_FU],
    input  logic              entry_rdy2 [1:sb_pkg::NUM_FU],
    output sb_pkg::fu_e       retire,
    output logic              reg_write,
    output sb_pkg::wb_sel_e   write_sel,
    output sb_pkg::reg_addr_t rd
);
    import sb_pkg::*;

    logic [NUM_FU:1] war_clear;
    logic [NUM_FU:1] can_retire;

    // WAR: hold while another unit still has to read our destination
    always_comb
    begin
        for (int u = 1; u <= NUM_FU; u++)
        begin
            war_clear[u] = 1'b1;
            for (int v = 1; v <= NUM_FU; v++)
            begin
                if (v != u && entry_dst[u] != '0)
                begin
                    if (entry_rdy1[v] && entry_src1[v] == entry_dst[u])
                        war_clear[u] = 1'b0;
                    if (entry_rdy2[v] && entry_src2[v] == entry_dst[u])
                        war_clear[u] = 1'b0;
                end
            end
            can_retire[u] = entry_busy[u] && entry_done[u] && war_clear[u];
        end
    end

    always_comb
    begin
        retire = fu_none;
        for (int u = NUM_FU; u >= 1; u--)
        begin
            if (can_retire[u])
                retire = fu_e'(u);
        end
    end

    // stores free their slot without a write
    assign reg_write = retire != fu_none && entry_dst[retire] != '0;
    assign rd        = reg_write ? entry_dst[retire] : '0;

    always_comb
    begin
        case (retire)
            fu_mem:  write_sel = wb_mem;
            fu_mul:  write_sel = wb_mul;
            default: write_sel = wb_alu;
        endcase
    end

    // a retired unit is empty on the next cycle
    a_wb_rd: assert property (@(posedge clk) disable iff (rst)
        retire != fu_none |=> !entry_busy[$past(retire)]);

endmodule

// File: logic/operand_read_arbiter.sv
`timescale 1ns/1ps

module operand_read_arbiter #(
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              entry_rdy1 [1:sb_pkg::NUM_FU],
    input  logic              entry_rdy2 [1:sb_pkg::NUM_FU],
    input  sb_pkg::op_t       entry_op   [1:sb_pkg::NUM_FU],
    input  sb_pkg::reg_addr_t entry_src1 [1:sb_pkg::NUM_FU],
    input  sb_pkg::reg_addr_t entry_src2 [1:sb_pkg::NUM_FU],
    input  logic [DATA_W-1:0] entry_imm  [1:sb_pkg::NUM_FU],
    output sb_pkg::fu_e       grant,
    output logic              alu_en,
    output logic              mem_en,
    output logic              mul_en,
    output sb_pkg::reg_addr_t rs1,
    output sb_pkg::reg_addr_t rs2,
    output logic [DATA_W-1:0] imm_out,
    output logic [3:0]        alu_op,
    output logic              alu_use_imm,
    output logic              mem_we,
    output logic [2:0]        mem_size,
    output logic [1:0]        mul_op
);
    import sb_pkg::*;

    // lowest tag wins, alu before mem before mul
    always_comb
    begin
        grant = fu_none;
        for (int u = NUM_FU; u >= 1; u--)
        begin
            if (entry_rdy1[u] && entry_rdy2[u])
                grant = fu_e'(u);
        end
    end

    assign alu_en = grant == fu_alu;
    assign mem_en = grant == fu_mem;
    assign mul_en = grant == fu_mul;

    always_comb
    begin
        rs1 = '0;
        rs2 = '0;
        imm_out = '0;
        alu_op = '0;
        alu_use_imm = 1'b0;
        mem_we = 1'b0;
        mem_size = '0;
        mul_op = '0;
        if (grant != fu_none)
        begin
            rs1 = entry_src1[grant];
            rs2 = entry_src2[grant];   // store data for mem
        end
        case (grant)
            fu_alu:
            begin
                alu_op = entry_op[fu_alu][3:0];
                alu_use_imm = entry_op[fu_alu][4];
                imm_out = entry_imm[fu_alu];
            end
            fu_mem:
            begin
                mem_we = entry_op[fu_mem][0];
                mem_size = entry_op[fu_mem][3:1];
                imm_out = entry_imm[fu_mem];
            end
            fu_mul: mul_op = entry_op[fu_mul][1:0];
            default: ;
        endcase
    end

    // never the same unit on two cycles running
    a_read_once: assert property (@(posedge clk) disable iff (rst)
        grant != fu_none |=> grant != $past(grant));

endmodule

// File: logic/fu_status_table.sv
`timescale 1ns/1ps

module fu_status_table #(
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid,
    input  sb_pkg::fu_e       fu,
    input  sb_pkg::op_t       op,
    input  sb_pkg::reg_addr_t dst,
    input  sb_pkg::reg_addr_t src1,
    input  sb_pkg::reg_addr_t src2,
    input  logic [DATA_W-1:0] imm,
    input  logic              alu_done,
    input  logic              mem_done,
    input  logic              mul_done,
    input  sb_pkg::fu_e       grant,
    input  sb_pkg::fu_e       retire,
    output logic              inst_ready,
    output logic              entry_busy [1:sb_pkg::NUM_FU],
    output logic              entry_done [1:sb_pkg::NUM_FU],
    output logic              entry_rdy1 [1:sb_pkg::NUM_FU],
    output logic              entry_rdy2 [1:sb_pkg::NUM_FU],
    output sb_pkg::op_t       entry_op   [1:sb_pkg::NUM_FU],
    output sb_pkg::reg_addr_t entry_dst  [1:sb_pkg::NUM_FU],
    output sb_pkg::reg_addr_t entry_src1 [1:sb_pkg::NUM_FU],
    output sb_pkg::reg_addr_t entry_src2 [1:sb_pkg::NUM_FU],
    output logic [DATA_W-1:0] entry_imm  [1:sb_pkg::NUM_FU]
);
    import sb_pkg::*;

    fu_e             tag1 [1:NUM_FU];   // producer still owed to src1
    fu_e             tag2 [1:NUM_FU];
    fu_e             rrs  [NUM_REGS];   // pending producer per register
    fu_e             tag1_now;
    fu_e             tag2_now;
    logic            rdy1_new;
    logic            rdy2_new;
    logic            issue;
    logic [NUM_FU:1] done_in;

    assign done_in = {mul_done, mem_done, alu_done};

    // structural hazard or WAW
    assign inst_ready = !((fu != fu_none && entry_busy[fu]) ||
                          (dst != '0 && rrs[dst] != fu_none));
    assign issue = inst_valid && inst_ready && fu != fu_none;

    assign tag1_now = rrs[src1];
    assign tag2_now = rrs[src2];
    // producer retiring on this edge counts as written
    assign rdy1_new = tag1_now == fu_none || tag1_now == retire;
    assign rdy2_new = tag2_now == fu_none || tag2_now == retire;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int r = 0; r < NUM_REGS; r++)
            begin
                rrs[r] <= fu_none;
            end
            for (int u = 1; u <= NUM_FU; u++)
            begin
                entry_busy[u] <= 1'b0;
                entry_done[u] <= 1'b0;
                entry_rdy1[u] <= 1'b0;
                entry_rdy2[u] <= 1'b0;
                tag1[u] <= fu_none;
                tag2[u] <= fu_none;
            end
        end
        else
        begin
            for (int u = 1; u <= NUM_FU; u++)
            begin
                if (grant == u)   // operands read this cycle
                begin
                    entry_rdy1[u] <= 1'b0;
                    entry_rdy2[u] <= 1'b0;
                end
                // RAW wakeup
                if (retire != fu_none && tag1[u] == retire)
                begin
                    entry_rdy1[u] <= 1'b1;
                    tag1[u] <= fu_none;
                end
                if (retire != fu_none && tag2[u] == retire)
                begin
                    entry_rdy2[u] <= 1'b1;
                    tag2[u] <= fu_none;
                end
                if (done_in[u])
                    entry_done[u] <= 1'b1;
                if (retire == u)
                begin
                    entry_busy[u] <= 1'b0;
                    entry_done[u] <= 1'b0;
                    entry_rdy1[u] <= 1'b0;
                    entry_rdy2[u] <= 1'b0;
                end
            end

            if (retire != fu_none)
                rrs[entry_dst[retire]] <= fu_none;

            if (issue)
            begin
                if (dst != '0)
                    rrs[dst] <= fu;
                entry_busy[fu] <= 1'b1;
                entry_done[fu] <= 1'b0;
                entry_rdy1[fu] <= rdy1_new;
                entry_rdy2[fu] <= rdy2_new;
                tag1[fu] <= rdy1_new ? fu_none : tag1_now;
                tag2[fu] <= rdy2_new ? fu_none : tag2_now;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            entry_op[fu] <= op;
            entry_dst[fu] <= dst;
            entry_src1[fu] <= src1;
            entry_src2[fu] <= src2;
            entry_imm[fu] <= imm;
        end
    end

    // a busy entry is never overwritten by a new issue
    for (genvar u = 1; u <= NUM_FU; u++)
    begin : g_busy_hold
        a_issue_free: assert property (@(posedge clk) disable iff (rst)
            entry_busy[u] && retire != u |=>
                entry_busy[u] && entry_op[u] == $past(entry_op[u]) &&
                entry_dst[u] == $past(entry_dst[u]));
    end

endmodule

// File: logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [31:0]       inst,
    output sb_pkg::fu_e       fu,
    output sb_pkg::op_t       op,
    output sb_pkg::reg_addr_t dst,
    output sb_pkg::reg_addr_t src1,
    output sb_pkg::reg_addr_t src2,
    output sb_pkg::imm_sel_e  imm_sel
);
    import sb_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       use_rd;
    logic       use_rs1;
    logic       use_rs2;
    imm_sel_e   imm_fmt;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb
    begin
        fu = fu_none;
        op = '0;
        use_rd = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        imm_fmt = imm_none;
        case (opcode)
            op_reg:
            begin
                use_rd = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (funct7 == 7'h01 && !funct3[2])
                begin
                    fu = fu_mul;
                    op = {3'b000, funct3[1:0]};   // mul variants follow funct3
                end
                else if (funct7 == 7'h00 || funct7 == 7'h20)
                begin
                    fu = fu_alu;
                    case ({funct7[5], funct3})
                        4'h0: op = alu_add;
                        4'h8: op = alu_sub;
                        4'h1: op = alu_sll;
                        4'h2: op = alu_slt;
                        4'h3: op = alu_sltu;
                        4'h4: op = alu_xor;
                        4'h5: op = alu_srl;
                        4'hd: op = alu_sra;
                        4'h6: op = alu_or;
                        4'h7: op = alu_and;
                        default: fu = fu_none;
                    endcase
                end
            end
            op_imm:
            begin
                fu = fu_alu;
                use_rd = 1'b1;
                use_rs1 = 1'b1;
                imm_fmt = imm_i;
                case (funct3)
                    3'h0: op = alu_addi;
                    3'h1: op = alu_slli;
                    3'h2: op = alu_slti;
                    3'h3: op = alu_sltiu;
                    3'h4: op = alu_xori;
                    3'h5: op = funct7[5] ? alu_srai : alu_srli;
                    3'h6: op = alu_ori;
                    default: op = alu_andi;
                endcase
                // shift amounts only, no stray funct7 bits
                if (funct3[1:0] == 2'b01 && funct7 != 7'h00 && !(funct3[2] && funct7 == 7'h20))
                    fu = fu_none;
            end
            op_load:
            begin
                fu = fu_mem;
                use_rd = 1'b1;
                use_rs1 = 1'b1;
                imm_fmt = imm_i;
                case (funct3)
                    3'h0: op = mem_lb;
                    3'h1: op = mem_lh;
                    3'h2: op = mem_lw;
                    3'h4: op = mem_lbu;
                    3'h5: op = mem_lhu;
                    default: fu = fu_none;
                endcase
            end
            op_store:
            begin
                fu = fu_mem;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm_fmt = imm_s;
                case (funct3)
                    3'h0: op = mem_sb;
                    3'h1: op = mem_sh;
                    3'h2: op = mem_sw;
                    default: fu = fu_none;
                endcase
            end
            op_lui:
            begin
                fu = fu_alu;
                op = alu_lui;
                use_rd = 1'b1;
                imm_fmt = imm_u;
            end
            default: fu = fu_none;
        endcase
    end

    // unused fields read as x0
    assign dst     = (fu != fu_none && use_rd) ? inst[11:7] : '0;
    assign src1    = (fu != fu_none && use_rs1) ? inst[19:15] : '0;
    assign src2    = (fu != fu_none && use_rs2) ? inst[24:20] : '0;
    assign imm_sel = (fu != fu_none) ? imm_fmt : imm_none;

endmodule

// File: logic/sb_pkg.sv
package sb_pkg;

    // unit tags, fu_none doubles as "no producer"
    typedef enum logic [1:0] {
        fu_none = 2'd0,
        fu_alu  = 2'd1,
        fu_mem  = 2'd2,
        fu_mul  = 2'd3
    } fu_e;

    localparam int NUM_FU   = 3;
    localparam int NUM_REGS = 32;

    typedef logic [4:0] reg_addr_t;
    typedef logic [4:0] op_t;   // alu {use_imm, op}, mem {size, we}, mul {variant}

    // alu, bit 4 selects the immediate operand
    localparam op_t alu_add   = 5'b0_0000;
    localparam op_t alu_sub   = 5'b0_0001;
    localparam op_t alu_sll   = 5'b0_0010;
    localparam op_t alu_slt   = 5'b0_0011;
    localparam op_t alu_sltu  = 5'b0_0100;
    localparam op_t alu_xor   = 5'b0_0101;
    localparam op_t alu_srl   = 5'b0_0110;
    localparam op_t alu_sra   = 5'b0_0111;
    localparam op_t alu_or    = 5'b0_1000;
    localparam op_t alu_and   = 5'b0_1001;
    localparam op_t alu_addi  = 5'b1_0000;
    localparam op_t alu_slli  = 5'b1_0010;
    localparam op_t alu_slti  = 5'b1_0011;
    localparam op_t alu_sltiu = 5'b1_0100;
    localparam op_t alu_xori  = 5'b1_0101;
    localparam op_t alu_srli  = 5'b1_0110;
    localparam op_t alu_srai  = 5'b1_0111;
    localparam op_t alu_ori   = 5'b1_1000;
    localparam op_t alu_andi  = 5'b1_1001;
    localparam op_t alu_lui   = 5'b1_1010;

    // mem, size is funct3
    localparam op_t mem_lb  = 5'b0_000_0;
    localparam op_t mem_lh  = 5'b0_001_0;
    localparam op_t mem_lw  = 5'b0_010_0;
    localparam op_t mem_lbu = 5'b0_100_0;
    localparam op_t mem_lhu = 5'b0_101_0;
    localparam op_t mem_sb  = 5'b0_000_1;
    localparam op_t mem_sh  = 5'b0_001_1;
    localparam op_t mem_sw  = 5'b0_010_1;

    localparam op_t mul_mul    = 5'd0;
    localparam op_t mul_mulh   = 5'd1;
    localparam op_t mul_mulhsu = 5'd2;
    localparam op_t mul_mulhu  = 5'd3;

    typedef enum logic [2:0] {
        imm_none = 3'd0,
        imm_i    = 3'd1,
        imm_s    = 3'd2,
        imm_u    = 3'd3
    } imm_sel_e;

    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_lui   = 7'b0110111;

    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1,
        wb_mul = 2'd2
    } wb_sel_e;

endpackage
